//--- ibi_tx.f
source/ibi_pkg.sv
source/ibi_byte_if.sv
source/ibi_queue.sv
source/descriptor_ibi.sv
source/ibi_bit_serializer.sv
source/ibi_tx.sv
tests/tb_clock.sv
tests/ibi_tx_checker.sv
tests/ibi_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the IBI transmit testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ibi_tx_tb -f ibi_tx.f -o ibi_tx_sim \
  && ./obj_dir/ibi_tx_sim | tee /dev/stderr | grep -x "Test passed" > /dev/null \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }

//--- source/descriptor_ibi.sv
// IBI descriptor unit that waits for the whole payload then streams MDB and payload bytes
module descriptor_ibi (
  input  logic                clk_i,
  input  logic                rst_ni,

  // TTI IBI queue read side
  input  logic                queue_rvalid_i,
  input  ibi_pkg::ibi_word_t  queue_rdata_i,
  input  ibi_pkg::ibi_depth_t queue_depth_i,
  output logic                queue_rready_o,

  // Byte stream towards the bus FSM
  ibi_byte_if.source          byte_o
);
  import ibi_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    DescLatch,
    DescPop,
    WriteMdb,
    WriteData
  } state_e;

  state_e state_q;
  state_e state_d;

  // Length field of the head word
  logic [IbiFieldWidth-1:0] desc_len;

  // Latched descriptor
  ibi_byte_t                mdb_q;
  // Length minus one with all ones for no payload
  logic [IbiFieldWidth-1:0] len_q;
  // Payload words rounded up
  logic [IbiFieldWidth-1:0] words_q;

  // Accepted payload bytes
  logic [IbiFieldWidth-1:0] cnt_q;
  logic [IbiLaneWidth-1:0]  lane;

  logic byte_fire;
  logic data_last;
  logic data_pop;
  logic no_payload;

  assign desc_len   = queue_rdata_i[IbiLenLsb +: IbiFieldWidth];
  assign byte_fire  = byte_o.valid && byte_o.ready;
  assign no_payload = &len_q;

  // Byte lane picked by the low counter bits
  assign lane      = cnt_q[IbiLaneWidth-1:0];
  assign data_last = (cnt_q == len_q);
  // Word leaves with its fourth byte or the last byte of the IBI
  assign data_pop  = (&lane) || data_last;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (queue_rvalid_i) begin
          state_d = DescLatch;
        end
      end
      DescLatch: begin
        // Payload words plus the descriptor itself must be stored
        if (IbiFieldWidth'(queue_depth_i) >= words_q + 1'b1) begin
          state_d = DescPop;
        end
      end
      DescPop: state_d = WriteMdb;
      WriteMdb: begin
        if (byte_fire) begin
          state_d = no_payload ? Idle : WriteData;
        end
      end
      WriteData: begin
        if (byte_fire && data_last) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Descriptor capture when the head word shows up
  always_ff @(posedge clk_i) begin
    if (state_q == Idle && queue_rvalid_i) begin
      mdb_q   <= queue_rdata_i[IbiMdbLsb +: IbiFieldWidth];
      len_q   <= desc_len - 1'b1;
      words_q <= (desc_len >> IbiLaneWidth) + IbiFieldWidth'(|desc_len[IbiLaneWidth-1:0]);
    end
  end

  // Payload byte counter that advances on accepted bytes only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (state_q == Idle) begin
      cnt_q <= '0;
    end else if (state_q == WriteData && byte_fire) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Descriptor pop then payload words as they drain
  assign queue_rready_o = (state_q == DescPop && queue_rvalid_i) ||
                          (state_q == WriteData && byte_fire && data_pop);

  // MDB first then payload lanes of the head word
  always_comb begin
    byte_o.valid = 1'b0;
    byte_o.data  = mdb_q;
    byte_o.last  = 1'b0;
    if (state_q == WriteMdb) begin
      byte_o.valid = 1'b1;
      byte_o.last  = no_payload;
    end else if (state_q == WriteData) begin
      byte_o.valid = queue_rvalid_i;
      byte_o.data  = queue_rdata_i[IbiByteWidth*lane +: IbiByteWidth];
      byte_o.last  = data_last;
    end
  end

endmodule

//--- source/ibi_bit_serializer.sv
// Bus bit serializer that sends each byte MSB first with an odd-parity T bit
module ibi_bit_serializer (
  input  logic    clk_i,
  input  logic    rst_ni,

  // Byte stream from the descriptor unit
  ibi_byte_if.sink byte_i,

  // Bus bit stream
  output logic    bit_valid_o,
  output logic    bit_o,
  output logic    frame_end_o
);
  import ibi_pkg::*;

  // Data bits then T bit shifted out from the top
  logic [IbiBitsPerByte-1:0] shift_q;
  logic [IbiBitCntWidth-1:0] bit_cnt_q;
  logic                      busy_q;
  // Byte in flight closes the IBI
  logic                      last_q;

  logic byte_fire;
  logic final_bit;
  logic t_bit;

  // Only takes a byte while idle
  assign byte_i.ready = !busy_q;
  assign byte_fire    = byte_i.valid && byte_i.ready;

  // T bit makes the nine bits odd parity
  assign t_bit = ~(^byte_i.data);

  assign final_bit = (bit_cnt_q == IbiBitCntWidth'(IbiBitsPerByte - 1));

  // Busy flag and bit counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      last_q    <= 1'b0;
    end else if (byte_fire) begin
      busy_q    <= 1'b1;
      bit_cnt_q <= '0;
      last_q    <= byte_i.last;
    end else if (busy_q) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
      // Ready again on the cycle after the T bit
      if (final_bit) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Shift register
  always_ff @(posedge clk_i) begin
    if (byte_fire) begin
      shift_q <= {byte_i.data, t_bit};
    end else if (busy_q) begin
      shift_q <= shift_q << 1;
    end
  end

  // One bus bit per cycle while busy
  assign bit_valid_o = busy_q;
  assign bit_o       = shift_q[IbiBitsPerByte-1];

  // End of IBI on the T bit of the last byte
  assign frame_end_o = busy_q && last_q && final_bit;

endmodule

//--- source/ibi_byte_if.sv
// IBI byte stream with valid/ready and last flag between descriptor unit and bus serializer
interface ibi_byte_if;
  import ibi_pkg::*;

  // Byte offered by the source
  logic      valid;
  // Sink can take a byte
  logic      ready;
  // MDB or payload byte
  ibi_byte_t data;
  // Final byte of the IBI
  logic      last;

  // Descriptor unit side
  modport source(
    output valid,
    output data,
    output last,
    input  ready
  );

  // Serializer side
  modport sink(
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

//--- source/ibi_pkg.sv
// IBI transmit path package with queue sizing, descriptor layout and shared types
package ibi_pkg;

  // Queue word and bus byte widths
  localparam int unsigned IbiWordWidth = 32;
  localparam int unsigned IbiByteWidth = 8;

  // TTI IBI queue sizing
  localparam int unsigned IbiQueueDepth = 16;
  localparam int unsigned IbiPtrWidth = $clog2(IbiQueueDepth);
  // One extra bit so a full queue can be counted
  localparam int unsigned IbiDepthWidth = IbiPtrWidth + 1;

  // Descriptor plus 15 payload words fill the queue exactly
  localparam int unsigned IbiMaxLen = 60;

  // Descriptor field positions and the one-byte field width
  localparam int unsigned IbiMdbLsb = 24;
  localparam int unsigned IbiLenLsb = 0;
  localparam int unsigned IbiFieldWidth = 8;

  // Byte lanes within one queue word
  localparam int unsigned IbiBytesPerWord = IbiWordWidth / IbiByteWidth;
  localparam int unsigned IbiLaneWidth = $clog2(IbiBytesPerWord);

  // Eight data bits and the T bit on the bus
  localparam int unsigned IbiBitsPerByte = IbiByteWidth + 1;
  localparam int unsigned IbiBitCntWidth = $clog2(IbiBitsPerByte);

  // One queue word
  typedef logic [IbiWordWidth-1:0] ibi_word_t;

  // One byte on the stream
  typedef logic [IbiByteWidth-1:0] ibi_byte_t;

  // Queue occupancy
  typedef logic [IbiDepthWidth-1:0] ibi_depth_t;

endpackage

//--- source/ibi_queue.sv
// TTI IBI queue as a show-ahead FIFO with occupancy count and drop-on-full writes
module ibi_queue (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Software write port with a single-cycle strobe
  input  logic               wr_valid_i,
  input  ibi_pkg::ibi_word_t wr_data_i,

  // Read side towards the descriptor unit
  input  logic               rready_i,
  output logic               rvalid_o,
  output ibi_pkg::ibi_word_t rdata_o,
  output ibi_pkg::ibi_depth_t depth_o,
  output logic               full_o
);
  import ibi_pkg::*;

  // Storage array
  ibi_word_t mem_q [IbiQueueDepth];

  // Pointers wrap naturally on the power-of-two depth
  logic [IbiPtrWidth-1:0] wr_ptr_q;
  logic [IbiPtrWidth-1:0] rd_ptr_q;
  ibi_depth_t             count_q;

  logic push;
  logic pop;

  // Full and non-empty flags from the count
  assign full_o   = (count_q == IbiDepthWidth'(IbiQueueDepth));
  assign rvalid_o = (count_q != '0);

  // Writes while full are lost
  assign push = wr_valid_i && !full_o;
  assign pop  = rready_i && rvalid_o;

  // Head word shown ahead of the pop
  assign rdata_o = mem_q[rd_ptr_q];
  assign depth_o = count_q;

  // Storage write
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // Pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Occupancy count
  // Push and pop together leave it unchanged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- source/ibi_tx.sv
// IBI transmit path top chaining the queue, the descriptor unit and the bus bit serializer
module ibi_tx (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Software writes into the TTI IBI queue
  input  logic               wr_valid_i,
  input  ibi_pkg::ibi_word_t wr_data_i,

  // Queue status
  output logic               queue_full_o,

  // Bus bit stream
  output logic               bit_valid_o,
  output logic               bit_o,
  output logic               frame_end_o
);
  import ibi_pkg::*;

  // Queue read side
  logic       queue_rvalid;
  logic       queue_rready;
  ibi_word_t  queue_rdata;
  ibi_depth_t queue_depth;

  // Byte stream
  ibi_byte_if byte_if ();

  ibi_queue u_ibi_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_valid_i (wr_valid_i),
    .wr_data_i  (wr_data_i),
    .rready_i   (queue_rready),
    .rvalid_o   (queue_rvalid),
    .rdata_o    (queue_rdata),
    .depth_o    (queue_depth),
    .full_o     (queue_full_o)
  );

  descriptor_ibi u_descriptor_ibi (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .queue_rvalid_i (queue_rvalid),
    .queue_rdata_i  (queue_rdata),
    .queue_depth_i  (queue_depth),
    .queue_rready_o (queue_rready),
    .byte_o         (byte_if.source)
  );

  // Stands in for the target bus FSM
  ibi_bit_serializer u_ibi_bit_serializer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .byte_i      (byte_if.sink),
    .bit_valid_o (bit_valid_o),
    .bit_o       (bit_o),
    .frame_end_o (frame_end_o)
  );

endmodule

//--- tests/ibi_tx_checker.sv
// IBI bit stream checker that rebuilds bytes from bus bits and compares them with the model
module ibi_tx_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic bit_valid_i,
  input logic bit_i,
  input logic frame_end_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import ibi_pkg::*;

  // Expected bytes and last flags filled by the model
  ibi_byte_t exp_data_q [$];
  logic      exp_last_q [$];

  int unsigned mismatch_count = 0;
  int unsigned other_count = 0;
  int unsigned byte_count = 0;

  // Bits of the byte in flight with the first bit at the top
  logic [IbiBitsPerByte-1:0] bits_q = '0;
  int unsigned               bit_idx = 0;

  // Model side pushes one byte per call
  task automatic push_expected(input ibi_byte_t data, input logic last);
    exp_data_q.push_back(data);
    exp_last_q.push_back(last);
  endtask

  // Nothing may be left over at the end of the run
  task automatic check_drained();
    if (bit_idx != 0) begin
      $display("error at %0d ns: bit stream stopped after %0d bits of a byte", $time, bit_idx);
      other_count++;
    end
    if (exp_data_q.size() != 0) begin
      $display("error at %0d ns: %0d expected bytes never appeared on the bus",
               $time, exp_data_q.size());
      other_count++;
    end
  endtask

  always @(posedge clk_i) begin : monitor
    logic [IbiBitsPerByte-1:0] word;
    ibi_byte_t                 got_data;
    ibi_byte_t                 exp_data;
    logic                      exp_last;
    logic                      exp_end;
    if (!rst_ni) begin
      bit_idx = 0;
    end else if (bit_valid_i) begin
      exp_last = (exp_last_q.size() != 0) ? exp_last_q[0] : 1'b0;
      // Frame end only on the T bit of the closing byte
      exp_end = (bit_idx == IbiBitsPerByte - 1) && exp_last;
      if (frame_end_i !== exp_end) begin
        $display("mismatch at %0d ns: frame_end_o got %b expected %b", $time, frame_end_i,
                 exp_end);
        mismatch_count++;
      end
      word = {bits_q[IbiBitsPerByte-2:0], bit_i};
      if (bit_idx == IbiBitsPerByte - 1) begin
        got_data = word[IbiBitsPerByte-1:1];
        // Nine bits with the T bit must hold an odd number of ones
        if (($countones(word) % 2) != 1) begin
          $display("mismatch at %0d ns: bit_o T bit got %b expected %b", $time, word[0],
                   ~word[0]);
          mismatch_count++;
        end
        if (exp_data_q.size() == 0) begin
          $display("error at %0d ns: bus sent byte %02h while no byte was expected",
                   $time, got_data);
          other_count++;
        end else begin
          exp_data = exp_data_q.pop_front();
          void'(exp_last_q.pop_front());
          if (got_data !== exp_data) begin
            $display("mismatch at %0d ns: bit_o byte got %02h expected %02h", $time,
                     got_data, exp_data);
            mismatch_count++;
          end
          byte_count++;
        end
        bit_idx = 0;
      end else begin
        bits_q = word;
        bit_idx++;
      end
    end else begin
      if (frame_end_i !== 1'b0) begin
        $display("mismatch at %0d ns: frame_end_o got %b expected 0", $time, frame_end_i);
        mismatch_count++;
      end
      // Nine bits come back to back
      if (bit_idx != 0) begin
        $display("error at %0d ns: bit_valid_o dropped after %0d bits of a byte", $time,
                 bit_idx);
        other_count++;
        bit_idx = 0;
      end
    end
  end

endmodule

//--- tests/ibi_tx_tb.sv
// IBI transmit path testbench with seeded random IBIs, reference byte model and timeout
module ibi_tx_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ibi_pkg::*;

  localparam int unsigned NumIbis = 40;
  localparam int unsigned ResetCycles = 5;
  localparam int unsigned Seed = 46663;
  // Longest IBI takes 61 bytes of 10 cycles plus writes and waits
  localparam int unsigned CyclesPerIbi = (IbiMaxLen + 1) * 10 + 64;
  // Rounded up to the next 10000
  localparam int unsigned TimeoutCycles = ((NumIbis * CyclesPerIbi) / 10000 + 1) * 10000;

  logic      clk;
  logic      rst_n;
  logic      wr_valid;
  ibi_word_t wr_data;
  logic      queue_full;
  logic      bit_valid;
  logic      bus_bit;
  logic      frame_end;

  // No IBI in progress so the bus is quiet and the queue empty
  logic idle_gap;
  // Descriptor written but payload not yet complete
  logic payload_pending;

  int unsigned cycle_count = 0;
  int unsigned tb_mismatches = 0;
  int unsigned tb_other = 0;

  tb_clock u_clock (
    .clk_o (clk)
  );

  ibi_tx uut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .wr_valid_i   (wr_valid),
    .wr_data_i    (wr_data),
    .queue_full_o (queue_full),
    .bit_valid_o  (bit_valid),
    .bit_o        (bus_bit),
    .frame_end_o  (frame_end)
  );

  ibi_tx_checker u_checker (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .bit_valid_i (bit_valid),
    .bit_i       (bus_bit),
    .frame_end_i (frame_end)
  );

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("mismatch at %0d ns: %s got %b expected 0", $time, name, value);
      tb_mismatches++;
    end
  endtask

  task automatic print_summary();
    $display("%0d mismatches, %0d other errors, %0d bytes checked",
             tb_mismatches + u_checker.mismatch_count, tb_other + u_checker.other_count,
             u_checker.byte_count);
  endtask

  // One IBI with model update, descriptor and payload words, then its frame end
  task automatic send_ibi(input int unsigned len);
    ibi_byte_t   mdb;
    int unsigned num_words;
    int unsigned gap;
    ibi_byte_t   payload [IbiMaxLen];
    ibi_word_t   word;
    logic        exp_full;
    mdb = ibi_byte_t'($urandom());
    num_words = (len + IbiBytesPerWord - 1) / IbiBytesPerWord;
    for (int unsigned i = 0; i < len; i++) begin
      payload[i] = ibi_byte_t'($urandom());
    end
    // Expected order is MDB then payload bytes
    u_checker.push_expected(mdb, len == 0);
    for (int unsigned i = 0; i < len; i++) begin
      u_checker.push_expected(payload[i], i == len - 1);
    end
    word = '0;
    word[IbiMdbLsb +: IbiFieldWidth] = mdb;
    word[IbiLenLsb +: IbiFieldWidth] = IbiFieldWidth'(len);
    @(posedge clk);
    wr_valid        <= 1'b1;
    wr_data         <= word;
    idle_gap        <= 1'b0;
    payload_pending <= (len != 0);
    for (int unsigned w = 0; w < num_words; w++) begin
      // Junk in unused lanes of the last word
      word = ibi_word_t'($urandom());
      for (int unsigned b = 0; b < IbiBytesPerWord; b++) begin
        if (w * IbiBytesPerWord + b < len) begin
          word[b*IbiByteWidth +: IbiByteWidth] = payload[w*IbiBytesPerWord+b];
        end
      end
      gap = $urandom_range(3, 0);
      repeat (gap) begin
        @(posedge clk);
        wr_valid <= 1'b0;
      end
      @(posedge clk);
      wr_valid <= 1'b1;
      wr_data  <= word;
      if (w == num_words - 1) begin
        payload_pending <= 1'b0;
      end
    end
    @(posedge clk);
    wr_valid <= 1'b0;
    // All words stored and the descriptor not yet popped
    @(posedge clk);
    exp_full = (num_words + 1 == IbiQueueDepth);
    if (queue_full !== exp_full) begin
      $display("mismatch at %0d ns: queue_full_o got %b expected %b", $time, queue_full,
               exp_full);
      tb_mismatches++;
    end
    do begin
      @(posedge clk);
    end while (frame_end !== 1'b1);
    idle_gap <= 1'b1;
  endtask

  // Bus quiet before the first IBI, between IBIs and while payload is incomplete
  always @(posedge clk) begin
    cycle_count++;
    if (idle_gap) begin
      expect_low("bit_valid_o", bit_valid);
      expect_low("frame_end_o", frame_end);
      expect_low("queue_full_o", queue_full);
    end
    if (payload_pending) begin
      expect_low("bit_valid_o", bit_valid);
    end
    if (cycle_count >= TimeoutCycles) begin
      $display("error at %0d ns: timeout after %0d cycles, the IBIs did not all finish",
               $time, cycle_count);
      tb_other++;
      print_summary();
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int unsigned len;
    rst_n           <= 1'b0;
    wr_valid        <= 1'b0;
    wr_data         <= '0;
    idle_gap        <= 1'b1;
    payload_pending <= 1'b0;
    void'($urandom(Seed));
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
    for (int unsigned n = 0; n < NumIbis; n++) begin
      // Empty and longest IBIs lead the random lengths
      if (n == 0) begin
        len = 0;
      end else if (n == 1) begin
        len = IbiMaxLen;
      end else begin
        len = $urandom_range(IbiMaxLen, 0);
      end
      send_ibi(len);
    end
    repeat (4) @(posedge clk);
    u_checker.check_drained();
    print_summary();
    if (tb_mismatches + tb_other + u_checker.mismatch_count + u_checker.other_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tests/tb_clock.sv
// Free-running testbench clock source with a 4 ns period
module tb_clock (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Half of the 4 ns period
  localparam int unsigned HalfPeriodNs = 2;

  initial begin
    clk_o = 1'b0;
  end

  always #(HalfPeriodNs) clk_o = ~clk_o;

endmodule
